// ==== adder_pkg.sv ====
`default_nettype none

package adder_pkg;

	// Operand width. The doubling scheme needs a power of two here
	localparam int ADDER_WIDTH = 64;

	// One doubling level per power of two below the width
	localparam int PREFIX_LEVELS = $clog2(ADDER_WIDTH);

	// Carry status of a span of bits
	// The high bit is the OR of the operand bits and the low bit their AND,
	// so the pattern 01 cannot come out of the encoder
	typedef enum logic [1:0]
	{
		KPG_KILL      = 2'b00,
		KPG_PROPAGATE = 2'b10,
		KPG_GENERATE  = 2'b11
	} kpg_t;

	// Payload accepted at the adder input
	typedef struct packed
	{
		logic [ADDER_WIDTH-1:0] a;
		logic [ADDER_WIDTH-1:0] b;
	} operands_t;

	// Payload carried through the prefix network
	typedef struct packed
	{
		kpg_t [ADDER_WIDTH-1:0] kpg;      // Status of the span that ends at each bit
		logic [ADDER_WIDTH-1:0] half_sum; // Sum bits before any carry is applied
	} prefix_t;

	// Payload delivered at the adder output
	typedef struct packed
	{
		logic [ADDER_WIDTH-1:0] sum;
		logic                   carry_out;
	} result_t;

endpackage

`default_nettype wire

// ==== kpg_encode.sv ====
`timescale 1ns/1ns
`default_nettype none

module kpg_encode import adder_pkg::*;
(
	input  logic      clk,
	input  logic      rst,

	input  logic      in_valid,
	output logic      in_ready,
	input  operands_t in_data,

	output logic      out_valid,
	input  logic      out_ready,
	output prefix_t   out_data
);

	logic    accept;
	prefix_t next_data;

	// The slot takes a new pair when empty or when its pair leaves this cycle
	assign in_ready = ~out_valid | out_ready;
	assign accept   = in_valid & in_ready;

	// Every bit pair starts out as a span of one bit
	always_comb
	begin
		for (int i = 0; i < ADDER_WIDTH; i++)
		begin
			next_data.kpg[i] = kpg_t'({in_data.a[i] | in_data.b[i],
				in_data.a[i] & in_data.b[i]});
		end
		next_data.half_sum = in_data.a ^ in_data.b;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			out_valid <= 1'b0;
		else if (in_ready)
			out_valid <= in_valid; // Drops when the item leaves and nothing follows
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			out_data <= next_data;
	end

endmodule

`default_nettype wire

// ==== prefix_pipeline.sv ====
`timescale 1ns/1ns
`default_nettype none

module prefix_pipeline import adder_pkg::*;
#(
	parameter int LEVELS_PER_STAGE = 2
)
(
	input  logic    clk,
	input  logic    rst,

	input  logic    in_valid,
	output logic    in_ready,
	input  prefix_t in_data,

	output logic    out_valid,
	input  logic    out_ready,
	output prefix_t out_data
);

	// Number of register slots, the last one may hold fewer levels
	localparam int STAGES = (PREFIX_LEVELS + LEVELS_PER_STAGE - 1) / LEVELS_PER_STAGE;

	typedef kpg_t [ADDER_WIDTH-1:0] kpg_vec_t;

	// Upper span decides unless it only passes on what comes from below
	function automatic kpg_t combine(input kpg_t upper, input kpg_t lower);
		if (upper == KPG_PROPAGATE)
			return lower;
		return upper;
	endfunction

	// One doubling step over all bits
	function automatic kpg_vec_t apply_level(input kpg_vec_t codes, input int span);
		kpg_vec_t result;
		for (int i = 0; i < ADDER_WIDTH; i++)
		begin
			if (i >= span)
				result[i] = combine(codes[i], codes[i - span]);
			else
				result[i] = combine(codes[i], KPG_KILL); // Nothing comes in below bit 0
		end
		return result;
	endfunction

	// Handshake chain, index 0 is the input side and index STAGES the output side
	logic    stage_valid [0:STAGES];
	logic    stage_ready [0:STAGES];
	prefix_t stage_data  [0:STAGES];

	assign stage_valid[0] = in_valid;
	assign stage_data[0]  = in_data;
	assign in_ready       = stage_ready[0];

	assign out_valid          = stage_valid[STAGES];
	assign out_data           = stage_data[STAGES];
	assign stage_ready[STAGES] = out_ready;

	for (genvar s = 0; s < STAGES; s++)
	begin : g_stage
		localparam int FIRST_LEVEL = s * LEVELS_PER_STAGE;

		prefix_t resolved;
		logic    valid_q;
		prefix_t data_q;
		logic    accept;

		// Spans double from level to level across the whole pipeline
		always_comb
		begin
			resolved = stage_data[s];
			for (int j = 0; j < LEVELS_PER_STAGE; j++)
			begin
				if (FIRST_LEVEL + j < PREFIX_LEVELS)
					resolved.kpg = apply_level(resolved.kpg, 1 << (FIRST_LEVEL + j));
			end
		end

		assign stage_ready[s] = ~valid_q | stage_ready[s + 1];
		assign accept         = stage_valid[s] & stage_ready[s];

		always_ff @(posedge clk)
		begin
			if (rst)
				valid_q <= 1'b0;
			else if (stage_ready[s])
				valid_q <= stage_valid[s];
		end

		// Half-sum rides along untouched
		always_ff @(posedge clk)
		begin
			if (accept)
				data_q <= resolved;
		end

		assign stage_valid[s + 1] = valid_q;
		assign stage_data[s + 1]  = data_q;
	end

endmodule

`default_nettype wire

// ==== sum_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module sum_stage import adder_pkg::*;
(
	input  logic    clk,
	input  logic    rst,

	input  logic    in_valid,
	output logic    in_ready,
	input  prefix_t in_data,

	output logic    out_valid,
	input  logic    out_ready,
	output result_t out_data
);

	logic                   accept;
	logic [ADDER_WIDTH-1:0] carry_in;
	result_t                next_result;

	assign in_ready = ~out_valid | out_ready;
	assign accept   = in_valid & in_ready;

	// After the last level each code covers bits 0 up to its own index,
	// so generate there means a carry leaves that bit
	always_comb
	begin
		carry_in[0] = 1'b0; // No carry-in port on this adder
		for (int i = 1; i < ADDER_WIDTH; i++)
			carry_in[i] = (in_data.kpg[i - 1] == KPG_GENERATE);
	end

	always_comb
	begin
		next_result.sum       = in_data.half_sum ^ carry_in;
		next_result.carry_out = (in_data.kpg[ADDER_WIDTH - 1] == KPG_GENERATE);
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			out_valid <= 1'b0;
		else if (in_ready)
			out_valid <= in_valid;
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			out_data <= next_result; // Held while the consumer stalls
	end

endmodule

`default_nettype wire

// ==== prefix_adder_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module prefix_adder_top import adder_pkg::*;
#(
	parameter int LEVELS_PER_STAGE = 2
)
(
	input  logic      clk,
	input  logic      rst,

	input  logic      in_valid,
	output logic      in_ready,
	input  operands_t in_data,

	output logic      out_valid,
	input  logic      out_ready,
	output result_t   out_data
);

	// Encoder to prefix network
	logic    enc_valid;
	logic    enc_ready;
	prefix_t enc_data;

	// Prefix network to sum stage
	logic    res_valid;
	logic    res_ready;
	prefix_t res_data;

	kpg_encode encode0
	(
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (in_data),
		.out_valid (enc_valid),
		.out_ready (enc_ready),
		.out_data  (enc_data)
	);

	// Codes leave here resolved down to bit 0
	prefix_pipeline
	#(
		.LEVELS_PER_STAGE (LEVELS_PER_STAGE)
	)
	prefix0
	(
		.clk       (clk),
		.rst       (rst),
		.in_valid  (enc_valid),
		.in_ready  (enc_ready),
		.in_data   (enc_data),
		.out_valid (res_valid),
		.out_ready (res_ready),
		.out_data  (res_data)
	);

	sum_stage sum0
	(
		.clk       (clk),
		.rst       (rst),
		.in_valid  (res_valid),
		.in_ready  (res_ready),
		.in_data   (res_data),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data)
	);

endmodule

`default_nettype wire

// ==== prefix_adder_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module prefix_adder_sva import adder_pkg::*;
#(
	parameter int LEVELS_PER_STAGE = 2
)
(
	input  logic    clk,
	input  logic    rst,
	input  logic    in_valid,
	input  logic    in_ready,
	input  logic    out_valid,
	input  logic    out_ready,
	input  result_t out_data
);

	localparam int STAGES  = (PREFIX_LEVELS + LEVELS_PER_STAGE - 1) / LEVELS_PER_STAGE;
	localparam int LATENCY = STAGES + 2;

	logic [LATENCY-1:0] fire_hist;
	logic [LATENCY-2:0] ready_hist;

	// Bit j holds the value from j+1 edges before the edge where it is checked
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			fire_hist  <= '0;
			ready_hist <= '0;
		end
		else
		begin
			fire_hist  <= {fire_hist[LATENCY-2:0], in_valid & in_ready};
			ready_hist <= {ready_hist[LATENCY-3:0], out_ready};
		end
	end

	stall_hold: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(out_data))
		else $error("Output item changed or vanished while stalled");

	// Also covers the first cycle after rst falls
	reset_state: assert property (@(posedge clk) rst |=> !out_valid && in_ready)
		else $error("Pipeline not empty and ready after reset");

	fixed_latency: assert property (@(posedge clk) disable iff (rst)
		fire_hist[LATENCY-1] && (&ready_hist) |-> out_valid)
		else $error("No output %0d cycles after an input transfer", LATENCY);

endmodule

bind prefix_adder_top prefix_adder_sva
#(
	.LEVELS_PER_STAGE (LEVELS_PER_STAGE)
)
sva0
(
	.clk       (clk),
	.rst       (rst),
	.in_valid  (in_valid),
	.in_ready  (in_ready),
	.out_valid (out_valid),
	.out_ready (out_ready),
	.out_data  (out_data)
);

`default_nettype wire

// ==== tb_prefix_adder.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_prefix_adder import adder_pkg::*;
();

	localparam int          LEVELS_PER_STAGE = 2;
	localparam int          STAGES           = (PREFIX_LEVELS + LEVELS_PER_STAGE - 1) /
		LEVELS_PER_STAGE;
	localparam int          LATENCY          = STAGES + 2;
	localparam int          CORNER_COUNT     = 8;
	localparam int          BURST_RANDOM     = 60;
	localparam int          STALL_RANDOM     = 240;
	localparam int          TRANSACTIONS     = CORNER_COUNT + BURST_RANDOM + STALL_RANDOM;
	localparam int          TIMEOUT_CYCLES   = TRANSACTIONS * LATENCY * 4 + 200;
	localparam logic [31:0] SEED             = 32'h5de6abed;

	logic      clk;
	logic      rst;
	logic      in_valid;
	logic      in_ready;
	operands_t in_data;
	logic      out_valid;
	logic      out_ready;
	result_t   out_data;

	logic [ADDER_WIDTH:0] expected_q [$]; // Carry out on top of the sum, in input order
	int                   in_count;
	int                   out_count;
	int                   cycle_count;
	logic [31:0]          data_state;
	logic [31:0]          ready_state;
	logic                 random_ready;

	prefix_adder_top
	#(
		.LEVELS_PER_STAGE (LEVELS_PER_STAGE)
	)
	dut0
	(
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (in_data),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Pairs that stress the carry chain in kill, propagate and generate
	function automatic operands_t corner_operands(input int k);
		operands_t pair;
		case (k)
			0: pair = {64'hffff_ffff_ffff_ffff, 64'h0000_0000_0000_0001};
			1: pair = {64'h0000_0000_0000_0000, 64'h0000_0000_0000_0000};
			2: pair = {64'h5555_5555_5555_5555, 64'haaaa_aaaa_aaaa_aaaa}; // All propagate
			3: pair = {64'h5555_5555_5555_5555, 64'h5555_5555_5555_5555};
			4: pair = {64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff}; // All generate
			5: pair = {64'haaaa_aaaa_aaaa_aaaa, 64'haaaa_aaaa_aaaa_aaaa};
			6: pair = {64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000};
			// Generate at bit 0 carried through 63 propagate bits
			default: pair = {64'h5555_5555_5555_5555, 64'haaaa_aaaa_aaaa_aaab};
		endcase
		return pair;
	endfunction

	task automatic stop_with_failure();
		$display("Something failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	// Holds the pair on the input until the monitor has counted its transfer
	task automatic send_pair(input operands_t pair);
		int start;
		start    = in_count;
		in_valid = 1'b1;
		in_data  = pair;
		while (in_count == start)
		begin
			@(posedge clk);
			#1;
		end
		in_valid = 1'b0;
	endtask

	task automatic send_random();
		operands_t pair;
		for (int i = 0; i < ADDER_WIDTH; i += 32)
		begin
			data_state     = lcg_next(data_state);
			pair.a[i +: 32] = data_state;
			data_state     = lcg_next(data_state);
			pair.b[i +: 32] = data_state;
		end
		send_pair(pair);
	endtask

	task automatic wait_for_drain();
		while (out_count != in_count)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	// About three cycles in four have out_ready high in the random phase
	initial
	begin
		logic use_random;
		forever
		begin
			@(posedge clk);
			use_random = random_ready;
			#1;
			if (use_random)
			begin
				ready_state = lcg_next(ready_state);
				out_ready   = (ready_state[31:30] != 2'b00);
			end
			else
				out_ready = 1'b1;
		end
	end

	// Scoreboard on both handshakes
	always @(posedge clk)
	begin
		logic [ADDER_WIDTH:0] expected;
		if (!rst)
		begin
			if (in_valid && in_ready)
			begin
				expected_q.push_back({1'b0, in_data.a} + {1'b0, in_data.b});
				in_count++;
			end
			if (out_valid && out_ready)
			begin
				if (expected_q.size() == 0)
				begin
					$display("An output arrived with no input left to match it");
					stop_with_failure();
				end
				else
				begin
					expected = expected_q.pop_front();
					assert (out_data.sum == expected[ADDER_WIDTH-1:0])
					else
					begin
						$display("[ERROR] out_data.sum expected %h got %h",
							expected[ADDER_WIDTH-1:0], out_data.sum);
						stop_with_failure();
					end
					assert (out_data.carry_out == expected[ADDER_WIDTH])
					else
					begin
						$display("[ERROR] out_data.carry_out expected %h got %h",
							expected[ADDER_WIDTH], out_data.carry_out);
						stop_with_failure();
					end
					out_count++;
				end
			end
		end
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES)
		begin
			$display("Timeout after %0d cycles with %0d of %0d results delivered",
				cycle_count, out_count, TRANSACTIONS);
			stop_with_failure();
		end
	end

	initial
	begin
		rst          = 1'b1;
		in_valid     = 1'b0;
		in_data      = '0;
		out_ready    = 1'b1;
		random_ready = 1'b0;
		data_state   = SEED;
		ready_state  = SEED ^ 32'hffff_ffff; // Own stream for out_ready
		in_count     = 0;
		out_count    = 0;
		cycle_count  = 0;

		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;

		// Burst with out_ready held high so each pair comes out after LATENCY cycles
		for (int k = 0; k < CORNER_COUNT; k++)
			send_pair(corner_operands(k));
		repeat (BURST_RANDOM) send_random();
		wait_for_drain();

		random_ready = 1'b1;
		repeat (STALL_RANDOM)
		begin
			data_state = lcg_next(data_state);
			if (data_state[31:29] == 3'd0)
			begin
				@(posedge clk); // Idle cycle on the input
				#1;
			end
			send_random();
		end
		wait_for_drain();

		// Once the last result has left nothing may remain in the pipeline
		if (!out_valid && expected_q.size() == 0 && in_count == TRANSACTIONS &&
			out_count == TRANSACTIONS)
		begin
			$display("Everything OK");
			$finish;
		end
		else
		begin
			$display("Extra output or count mismatch with %0d inputs, %0d outputs, %0d pending",
				in_count, out_count, expected_q.size());
			stop_with_failure();
		end
	end

endmodule

`default_nettype wire

// ==== list.f ====
adder_pkg.sv
kpg_encode.sv
prefix_pipeline.sv
sum_stage.sv
prefix_adder_top.sv
prefix_adder_sva.sv
tb_prefix_adder.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_prefix_adder
FILELIST  = list.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_TEXT = Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# The simulator status is ignored, the log search decides pass or fail
run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
